// File: source/rn_cfg_pkg.sv
// Geometry is fixed at two lanes and two commits; free list depth must be a power of two
package rn_cfg_pkg;

   // Logical register file
   localparam int LRF_AW = 5;
   localparam int N_LRF = 32;

   // Physical register file
   localparam int PRF_AW = 6;
   localparam int N_PRF = 64;

   // Lanes renamed per group
   localparam int IW = 2;
   // Commit slots per cycle
   localparam int CW = 2;

   // Registers outside the reset mapping, all free after reset
   localparam int FL_DEPTH = N_PRF - N_LRF;

   // One bit above the index tells a full list from an empty one
   localparam int FL_PTR_W = 6;

endpackage

// File: source/rn_types_pkg.sv
// Record layouts between rename blocks; field order fixes the packed bit layout
package rn_types_pkg;

   // One commit slot, pfree is the mapping lrd held before this instruction
   typedef struct packed {
      logic                          fire;
      logic                          prd_we;
      logic [rn_cfg_pkg::LRF_AW-1:0] lrd;
      logic [rn_cfg_pkg::PRF_AW-1:0] prd;
      logic [rn_cfg_pkg::PRF_AW-1:0] pfree;
   } rn_cmt_t;

   // One renamed lane as handed to dispatch
   typedef struct packed {
      logic [rn_cfg_pkg::PRF_AW-1:0] prs1;
      logic [rn_cfg_pkg::PRF_AW-1:0] prs2;
      logic [rn_cfg_pkg::PRF_AW-1:0] prd;
      logic [rn_cfg_pkg::PRF_AW-1:0] pfree;
      logic                          has_rd;
   } rn_out_t;

endpackage

// File: source/rn_lane_if.sv
// All lane fields are combinational within the rename cycle; nothing here is registered
`timescale 1ns/1ps

interface rn_lane_if;

   // Architectural fields of the incoming instruction
   logic [rn_cfg_pkg::LRF_AW-1:0] lrs1;
   logic [rn_cfg_pkg::LRF_AW-1:0] lrs2;
   logic [rn_cfg_pkg::LRF_AW-1:0] lrd;
   logic                          lrd_we;

   // Speculative table lookups before any bypass
   logic [rn_cfg_pkg::PRF_AW-1:0] tab_prs1;
   logic [rn_cfg_pkg::PRF_AW-1:0] tab_prs2;
   logic [rn_cfg_pkg::PRF_AW-1:0] tab_pfree;

   // Free list entry offered to this lane
   logic [rn_cfg_pkg::PRF_AW-1:0] new_prd;

   rn_types_pkg::rn_out_t         result;

   modport tbl   (input lrs1, lrs2, lrd, lrd_we, new_prd,
                  output tab_prs1, tab_prs2, tab_pfree);
   modport alloc (input lrd_we, output new_prd);
   modport lane  (input lrs1, lrs2, lrd, lrd_we, tab_prs1, tab_prs2, tab_pfree, new_prd,
                  output result);
   modport disp  (input result);

endinterface

// File: source/rn_free_list.sv
// Commits must arrive in allocation order or the committed head drifts from the real state
`timescale 1ns/1ps

module rn_free_list
(
   input  logic                                      clk,
   input  logic                                      rst_n,
   input  logic                                      fire,
   input  logic                                      rollback,
   input  rn_types_pkg::rn_cmt_t [rn_cfg_pkg::CW-1:0] cmt,
   rn_lane_if.alloc                                  lanes [rn_cfg_pkg::IW],
   output logic                                      fl_ok
);

   localparam int PW = rn_cfg_pkg::PRF_AW;
   localparam int QW = rn_cfg_pkg::FL_PTR_W;
   localparam int AW = QW - 1;

   logic [PW-1:0]             fl_mem [rn_cfg_pkg::FL_DEPTH];
   logic [QW-1:0]             spec_head;
   logic [QW-1:0]             cmt_head;
   logic [QW-1:0]             tail;
   logic [QW-1:0]             fl_cnt;
   // Running offsets from the head for lanes and from the tail for commits
   logic [QW-1:0]             alloc_off [rn_cfg_pkg::IW+1];
   logic [QW-1:0]             push_off [rn_cfg_pkg::CW+1];
   logic [QW-1:0]             rd_ptr [rn_cfg_pkg::IW];
   logic [QW-1:0]             wr_ptr [rn_cfg_pkg::CW];
   logic [rn_cfg_pkg::CW-1:0] push;

   genvar g;

   assign fl_cnt = tail - spec_head;
   assign alloc_off[0] = '0;
   assign push_off[0] = '0;

   generate
      for (g = 0; g < rn_cfg_pkg::IW; g++)
      begin : gen_alloc
         // Only writing lanes consume an entry
         assign alloc_off[g+1] = alloc_off[g] + QW'(lanes[g].lrd_we);
         assign rd_ptr[g] = spec_head + alloc_off[g];
         assign lanes[g].new_prd = fl_mem[rd_ptr[g][AW-1:0]];
      end

      for (g = 0; g < rn_cfg_pkg::CW; g++)
      begin : gen_push
         assign push[g] = cmt[g].fire & cmt[g].prd_we;
         assign push_off[g+1] = push_off[g] + QW'(push[g]);
         assign wr_ptr[g] = tail + push_off[g];
      end
   endgenerate

   assign fl_ok = fl_cnt >= alloc_off[rn_cfg_pkg::IW];

   // Pointers
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         spec_head <= '0;
         cmt_head <= '0;
         tail <= QW'(rn_cfg_pkg::FL_DEPTH);
      end
      else
      begin
         if (rollback)
            spec_head <= cmt_head;
         else if (fire)
            spec_head <= spec_head + alloc_off[rn_cfg_pkg::IW];
         // Each committed destination retires one entry and returns one
         cmt_head <= cmt_head + push_off[rn_cfg_pkg::CW];
         tail <= tail + push_off[rn_cfg_pkg::CW];
      end
   end

   // Entries, loaded with the registers above the identity mapping
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < rn_cfg_pkg::FL_DEPTH; i++)
            fl_mem[i] <= PW'(rn_cfg_pkg::N_LRF + i);
      end
      else
      begin
         for (int c = 0; c < rn_cfg_pkg::CW; c++)
         begin
            if (push[c])
               fl_mem[wr_ptr[c][AW-1:0]] <= cmt[c].pfree;
         end
      end
   end

   // A commit stream that frees more than was allocated would overrun the list
   assert property (@(posedge clk) disable iff (!rst_n)
      fl_cnt <= QW'(rn_cfg_pkg::FL_DEPTH))
      else $error("free list count %0d above depth", fl_cnt);

endmodule

// File: source/rn_rat.sv
// Lookups see the table before this edge's writes; the ROB must drain before a rollback
`timescale 1ns/1ps

module rn_rat
(
   input  logic                                      clk,
   input  logic                                      rst_n,
   input  logic                                      fire,
   input  logic                                      rollback,
   input  rn_types_pkg::rn_cmt_t [rn_cfg_pkg::CW-1:0] cmt,
   rn_lane_if.tbl                                    lanes [rn_cfg_pkg::IW]
);

   localparam int LW = rn_cfg_pkg::LRF_AW;
   localparam int PW = rn_cfg_pkg::PRF_AW;

   logic [PW-1:0]             spec_tab [rn_cfg_pkg::N_LRF];
   logic [PW-1:0]             arch_tab [rn_cfg_pkg::N_LRF];
   logic [rn_cfg_pkg::IW-1:0] wr_en;
   logic [LW-1:0]             wr_lr [rn_cfg_pkg::IW];
   logic [PW-1:0]             wr_pr [rn_cfg_pkg::IW];
   logic [rn_cfg_pkg::CW-1:0] cmt_fire;

   genvar g;

   generate
      for (g = 0; g < rn_cfg_pkg::IW; g++)
      begin : gen_lane
         assign lanes[g].tab_prs1 = spec_tab[lanes[g].lrs1];
         assign lanes[g].tab_prs2 = spec_tab[lanes[g].lrs2];
         assign lanes[g].tab_pfree = spec_tab[lanes[g].lrd];
         assign wr_en[g] = fire & lanes[g].lrd_we;
         assign wr_lr[g] = lanes[g].lrd;
         assign wr_pr[g] = lanes[g].new_prd;
      end

      for (g = 0; g < rn_cfg_pkg::CW; g++)
      begin : gen_cmt
         assign cmt_fire[g] = cmt[g].fire;
      end
   endgenerate

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         // Identity mapping
         for (int i = 0; i < rn_cfg_pkg::N_LRF; i++)
         begin
            spec_tab[i] <= PW'(i);
            arch_tab[i] <= PW'(i);
         end
      end
      else
      begin
         if (rollback)
            spec_tab <= arch_tab;
         else
         begin
            // Later lane wins on the same lrd
            for (int i = 0; i < rn_cfg_pkg::IW; i++)
            begin
               if (wr_en[i])
                  spec_tab[wr_lr[i]] <= wr_pr[i];
            end
         end
         // Slots are in program order so slot 1 overrides slot 0
         for (int c = 0; c < rn_cfg_pkg::CW; c++)
         begin
            if (cmt[c].fire && cmt[c].prd_we)
               arch_tab[cmt[c].lrd] <= cmt[c].prd;
         end
      end
   end

   // Copying the committed table is only exact when no commit lands in the same cycle
   assert property (@(posedge clk) disable iff (!rst_n)
      rollback |-> cmt_fire == '0)
      else $error("rollback together with commit %b", cmt_fire);

endmodule

// File: source/rn_lane.sv
// older carries the whole group and only entries below LANE are read; LANE must be below IW
`timescale 1ns/1ps

module rn_lane
#(
   parameter int LANE = 0
)
(
   rn_lane_if.lane lane,
   rn_lane_if.lane older [rn_cfg_pkg::IW]
);

   localparam int PW = rn_cfg_pkg::PRF_AW;

   // Select chains, entry k holds the choice after looking at older lanes below k
   logic [PW-1:0] prs1_c [LANE+1];
   logic [PW-1:0] prs2_c [LANE+1];
   logic [PW-1:0] pfree_c [LANE+1];

   genvar k;

   assign prs1_c[0] = lane.tab_prs1;
   assign prs2_c[0] = lane.tab_prs2;
   assign pfree_c[0] = lane.tab_pfree;

   generate
      for (k = 0; k < LANE; k++)
      begin : gen_byp
         // A younger older writer overrides everything before it
         assign prs1_c[k+1] = (older[k].lrd_we && older[k].lrd == lane.lrs1) ?
                              older[k].new_prd : prs1_c[k];
         assign prs2_c[k+1] = (older[k].lrd_we && older[k].lrd == lane.lrs2) ?
                              older[k].new_prd : prs2_c[k];
         // WAW in the group frees the older lane's fresh register
         assign pfree_c[k+1] = (older[k].lrd_we && older[k].lrd == lane.lrd) ?
                               older[k].new_prd : pfree_c[k];
      end
   endgenerate

   always_comb
   begin
      lane.result.prs1 = prs1_c[LANE];
      lane.result.prs2 = prs2_c[LANE];
      lane.result.has_rd = lane.lrd_we;
      // No destination, nothing allocated or freed
      lane.result.prd = lane.lrd_we ? lane.new_prd : '0;
      lane.result.pfree = lane.lrd_we ? pfree_c[LANE] : '0;
   end

endmodule

// File: source/rn_dispatch_reg.sv
// One-entry output stage; in_ready depends combinationally on the group's destination count
`timescale 1ns/1ps

module rn_dispatch_reg
(
   input  logic                                      clk,
   input  logic                                      rst_n,
   input  logic                                      in_valid,
   input  logic                                      fl_ok,
   input  logic                                      rollback,
   rn_lane_if.disp                                   lanes [rn_cfg_pkg::IW],
   input  logic                                      out_ready,
   output logic                                      in_ready,
   output logic                                      fire,
   output logic                                      out_valid,
   output rn_types_pkg::rn_out_t [rn_cfg_pkg::IW-1:0] out_lanes
);

   logic                                      run_q;
   logic                                      slot_free;
   rn_types_pkg::rn_out_t [rn_cfg_pkg::IW-1:0] res;

   genvar g;

   generate
      for (g = 0; g < rn_cfg_pkg::IW; g++)
      begin : gen_res
         assign res[g] = lanes[g].result;
      end
   endgenerate

   // Output slot drains this cycle or is already empty
   assign slot_free = !out_valid || out_ready;
   assign in_ready = run_q && fl_ok && slot_free && !rollback;
   assign fire = in_valid && in_ready;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         run_q <= 1'b0;
         out_valid <= 1'b0;
      end
      else
      begin
         run_q <= 1'b1;
         if (rollback)
            out_valid <= 1'b0;
         else if (fire)
            out_valid <= 1'b1;
         else if (out_ready)
            out_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (fire)
         out_lanes <= res;
   end

   assert property (@(posedge clk) disable iff (!rst_n)
      out_valid && !out_ready |=> $stable(out_lanes))
      else $error("out_lanes changed under back-pressure");

endmodule

// File: source/rn_rename_top.sv
// Commits use slot 0 before slot 1 and in program order; rollback only with no commit
`timescale 1ns/1ps

module rn_rename_top
(
   input  logic                                                   clk,
   input  logic                                                   rst_n,
   input  logic                                                   in_valid,
   input  logic [rn_cfg_pkg::IW-1:0][rn_cfg_pkg::LRF_AW-1:0]      in_lrs1,
   input  logic [rn_cfg_pkg::IW-1:0][rn_cfg_pkg::LRF_AW-1:0]      in_lrs2,
   input  logic [rn_cfg_pkg::IW-1:0][rn_cfg_pkg::LRF_AW-1:0]      in_lrd,
   input  logic [rn_cfg_pkg::IW-1:0]                              in_lrd_we,
   output logic                                                   in_ready,
   input  logic [rn_cfg_pkg::CW-1:0]                              cmt_fire,
   input  logic [rn_cfg_pkg::CW-1:0]                              cmt_prd_we,
   input  logic [rn_cfg_pkg::CW-1:0][rn_cfg_pkg::LRF_AW-1:0]      cmt_lrd,
   input  logic [rn_cfg_pkg::CW-1:0][rn_cfg_pkg::PRF_AW-1:0]      cmt_prd,
   input  logic [rn_cfg_pkg::CW-1:0][rn_cfg_pkg::PRF_AW-1:0]      cmt_pfree,
   input  logic                                                   rollback,
   output logic                                                   out_valid,
   output rn_types_pkg::rn_out_t [rn_cfg_pkg::IW-1:0]             out_lanes,
   input  logic                                                   out_ready
);

   rn_types_pkg::rn_cmt_t [rn_cfg_pkg::CW-1:0] cmt;
   logic                                      fire;
   logic                                      fl_ok;

   rn_lane_if lif [rn_cfg_pkg::IW] ();

   genvar g;

   generate
      for (g = 0; g < rn_cfg_pkg::CW; g++)
      begin : gen_cmt
         assign cmt[g] = '{fire: cmt_fire[g], prd_we: cmt_prd_we[g], lrd: cmt_lrd[g],
                           prd: cmt_prd[g], pfree: cmt_pfree[g]};
      end

      for (g = 0; g < rn_cfg_pkg::IW; g++)
      begin : gen_lane
         assign lif[g].lrs1 = in_lrs1[g];
         assign lif[g].lrs2 = in_lrs2[g];
         assign lif[g].lrd = in_lrd[g];
         assign lif[g].lrd_we = in_lrd_we[g];

         rn_lane #(.LANE(g)) u_lane (.lane(lif[g]), .older(lif));
      end
   endgenerate

   rn_rat u_rat
   (
      .clk      (clk),
      .rst_n    (rst_n),
      .fire     (fire),
      .rollback (rollback),
      .cmt      (cmt),
      .lanes    (lif)
   );

   rn_free_list u_free_list
   (
      .clk      (clk),
      .rst_n    (rst_n),
      .fire     (fire),
      .rollback (rollback),
      .cmt      (cmt),
      .lanes    (lif),
      .fl_ok    (fl_ok)
   );

   rn_dispatch_reg u_dispatch_reg
   (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .fl_ok     (fl_ok),
      .rollback  (rollback),
      .lanes     (lif),
      .out_ready (out_ready),
      .in_ready  (in_ready),
      .fire      (fire),
      .out_valid (out_valid),
      .out_lanes (out_lanes)
   );

endmodule

// File: dv/rn_rename_tb.sv
// Checks against a behavioral model; commits follow rename order and never meet a rollback
`timescale 1ns/1ps

module rn_rename_tb;

   localparam int LW = rn_cfg_pkg::LRF_AW;
   localparam int PW = rn_cfg_pkg::PRF_AW;
   localparam int IW = rn_cfg_pkg::IW;
   localparam int CW = rn_cfg_pkg::CW;
   localparam int TIMEOUT = 50;

   // One renamed destination waiting for commit
   typedef struct packed {
      logic [LW-1:0] lrd;
      logic [PW-1:0] prd;
      logic [PW-1:0] pfree;
   } dest_t;

   logic                           clk;
   logic                           rst_n;
   logic                           in_valid;
   logic [IW-1:0][LW-1:0]          in_lrs1;
   logic [IW-1:0][LW-1:0]          in_lrs2;
   logic [IW-1:0][LW-1:0]          in_lrd;
   logic [IW-1:0]                  in_lrd_we;
   logic                           in_ready;
   logic [CW-1:0]                  cmt_fire;
   logic [CW-1:0]                  cmt_prd_we;
   logic [CW-1:0][LW-1:0]          cmt_lrd;
   logic [CW-1:0][PW-1:0]          cmt_prd;
   logic [CW-1:0][PW-1:0]          cmt_pfree;
   logic                           rollback;
   logic                           out_valid;
   rn_types_pkg::rn_out_t [IW-1:0] out_lanes;
   logic                           out_ready;

   // Reference model
   logic [PW-1:0]         spec_tab [rn_cfg_pkg::N_LRF];
   logic [PW-1:0]         arch_tab [rn_cfg_pkg::N_LRF];
   logic [PW-1:0]         fl_q [$];
   int                    spec_idx;
   int                    cmt_idx;
   rn_types_pkg::rn_out_t exp_out [IW];
   logic                  exp_valid;
   dest_t                 inflight [$];

   logic [15:0]           lfsr;
   int                    val_errs;
   int                    tmo_errs;
   int                    i;

   rn_rename_top UUT (.*);

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Fibonacci LFSR with taps 16 14 13 11, one step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int b = 0; b < n; b++)
      begin
         fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
         lfsr = {lfsr[14:0], fb};
         r = {r[30:0], fb};
      end
      return r;
   endfunction

   function automatic int free_count();
      return fl_q.size() - spec_idx;
   endfunction

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp)
      else
      begin
         $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
         val_errs++;
      end
   endtask

   task automatic finish_run();
      $display("Errors: %0d value mismatches, %0d timeouts", val_errs, tmo_errs);
      if (val_errs == 0 && tmo_errs == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   endtask

   task automatic model_reset();
      fl_q.delete();
      inflight.delete();
      for (int r = 0; r < rn_cfg_pkg::N_LRF; r++)
      begin
         spec_tab[r] = PW'(r);
         arch_tab[r] = PW'(r);
      end
      for (int r = 0; r < rn_cfg_pkg::FL_DEPTH; r++)
         fl_q.push_back(PW'(rn_cfg_pkg::N_LRF + r));
      spec_idx = 0;
      cmt_idx = 0;
      exp_valid = 1'b0;
   endtask

   task automatic check_outputs();
      check_val("out_valid", 32'(out_valid), 32'(exp_valid));
      if (exp_valid)
      begin
         for (int k = 0; k < IW; k++)
         begin
            check_val($sformatf("out_lanes[%0d].has_rd", k), 32'(out_lanes[k].has_rd),
                      32'(exp_out[k].has_rd));
            check_val($sformatf("out_lanes[%0d].prs1", k), 32'(out_lanes[k].prs1),
                      32'(exp_out[k].prs1));
            check_val($sformatf("out_lanes[%0d].prs2", k), 32'(out_lanes[k].prs2),
                      32'(exp_out[k].prs2));
            if (exp_out[k].has_rd)
            begin
               check_val($sformatf("out_lanes[%0d].prd", k), 32'(out_lanes[k].prd),
                         32'(exp_out[k].prd));
               check_val($sformatf("out_lanes[%0d].pfree", k), 32'(out_lanes[k].pfree),
                         32'(exp_out[k].pfree));
            end
         end
      end
      // Back-pressure, a rollback and a short free list all hold the group off
      if (out_valid && !out_ready)
         check_val("in_ready", 32'(in_ready), 32'd0);
      if (rollback)
         check_val("in_ready", 32'(in_ready), 32'd0);
      if (in_valid && free_count() < $countones(in_lrd_we))
         check_val("in_ready", 32'(in_ready), 32'd0);
   endtask

   task automatic rename_group();
      int    used;
      dest_t d;
      used = 0;
      for (int k = 0; k < IW; k++)
      begin
         exp_out[k].has_rd = in_lrd_we[k];
         exp_out[k].prs1 = spec_tab[in_lrs1[k]];
         exp_out[k].prs2 = spec_tab[in_lrs2[k]];
         exp_out[k].pfree = spec_tab[in_lrd[k]];
         exp_out[k].prd = '0;
         // Older writers in the group override the table, youngest last
         for (int j = 0; j < k; j++)
         begin
            if (in_lrd_we[j] && in_lrd[j] == in_lrs1[k])
               exp_out[k].prs1 = exp_out[j].prd;
            if (in_lrd_we[j] && in_lrd[j] == in_lrs2[k])
               exp_out[k].prs2 = exp_out[j].prd;
            if (in_lrd_we[j] && in_lrd[j] == in_lrd[k])
               exp_out[k].pfree = exp_out[j].prd;
         end
         if (in_lrd_we[k])
         begin
            exp_out[k].prd = fl_q[spec_idx + used];
            used++;
            d.lrd = in_lrd[k];
            d.prd = exp_out[k].prd;
            d.pfree = exp_out[k].pfree;
            inflight.push_back(d);
         end
      end
      for (int k = 0; k < IW; k++)
      begin
         if (in_lrd_we[k])
            spec_tab[in_lrd[k]] = exp_out[k].prd;
      end
      spec_idx += used;
      exp_valid = 1'b1;
   endtask

   task automatic apply_commits();
      for (int c = 0; c < CW; c++)
      begin
         if (cmt_fire[c] && cmt_prd_we[c])
         begin
            arch_tab[cmt_lrd[c]] = cmt_prd[c];
            fl_q.push_back(cmt_pfree[c]);
            cmt_idx++;
         end
      end
   endtask

   // Inputs only move on the rising edge, so the falling edge sees settled values
   always @(negedge clk)
   begin
      if (!rst_n)
         model_reset();
      else
      begin
         check_outputs();
         if (rollback)
         begin
            spec_tab = arch_tab;
            spec_idx = cmt_idx;
            exp_valid = 1'b0;
            inflight.delete();
         end
         else if (in_valid && in_ready)
            rename_group();
         else if (out_ready)
            exp_valid = 1'b0;
         apply_commits();
      end
   end

   task automatic rand_group(input logic [IW-1:0] we);
      for (int k = 0; k < IW; k++)
      begin
         in_lrs1[k] <= LW'(rand_bits(LW));
         in_lrs2[k] <= LW'(rand_bits(LW));
         in_lrd[k] <= LW'(rand_bits(LW));
      end
      in_lrd_we <= we;
      in_valid <= 1'b1;
   endtask

   task automatic wait_fire(input logic rand_ready);
      bit fired;
      fired = 1'b0;
      for (int t = 0; t < TIMEOUT && !fired; t++)
      begin
         @(negedge clk);
         fired = in_ready;
         @(posedge clk);
         if (rand_ready)
            out_ready <= 1'(rand_bits(1));
      end
      in_valid <= 1'b0;
      if (!fired)
      begin
         $display("Timed out waiting for the rename stage to accept a group");
         tmo_errs++;
         finish_run();
      end
   endtask

   task automatic do_commits(input int n);
      int    left;
      dest_t d;
      left = n;
      while (left > 0 && inflight.size() > 0)
      begin
         for (int c = 0; c < CW; c++)
         begin
            cmt_fire[c] <= 1'b0;
            if (left > 0 && inflight.size() > 0)
            begin
               d = inflight.pop_front();
               cmt_fire[c] <= 1'b1;
               cmt_prd_we[c] <= 1'b1;
               cmt_lrd[c] <= d.lrd;
               cmt_prd[c] <= d.prd;
               cmt_pfree[c] <= d.pfree;
               left--;
            end
         end
         @(posedge clk);
      end
      cmt_fire <= '0;
   endtask

   task automatic do_rollback();
      rollback <= 1'b1;
      @(posedge clk);
      rollback <= 1'b0;
   endtask

   initial
   begin
      rst_n = 1'b0;
      in_valid = 1'b0;
      in_lrs1 = '0;
      in_lrs2 = '0;
      in_lrd = '0;
      in_lrd_we = '0;
      cmt_fire = '0;
      cmt_prd_we = '0;
      cmt_lrd = '0;
      cmt_prd = '0;
      cmt_pfree = '0;
      rollback = 1'b0;
      out_ready = 1'b1;
      lfsr = 16'd19772;
      val_errs = 0;
      tmo_errs = 0;
      repeat (2) @(posedge clk);
      // Both handshake outputs stay low while reset is held
      @(negedge clk);
      check_val("in_ready", 32'(in_ready), 32'd0);
      check_val("out_valid", 32'(out_valid), 32'd0);
      @(posedge clk);
      rst_n <= 1'b1;

      // Identity mapping seen by a group with no destinations
      rand_group(2'b00);
      wait_fire(1'b0);
      for (i = 0; i < 4; i++)
      begin
         rand_group(2'b11);
         wait_fire(1'b0);
      end

      // RAW on lrs1 with WAW on the same register, then RAW on lrs2
      rand_group(2'b11);
      in_lrd[0] <= LW'(7);
      in_lrs1[1] <= LW'(7);
      in_lrd[1] <= LW'(7);
      wait_fire(1'b0);
      rand_group(2'b11);
      in_lrd[0] <= LW'(9);
      in_lrs2[1] <= LW'(9);
      in_lrd[1] <= LW'(10);
      wait_fire(1'b0);

      // Output held under back-pressure
      rand_group(2'b11);
      wait_fire(1'b0);
      out_ready <= 1'b0;
      rand_group(2'b11);
      repeat (4) @(posedge clk);
      out_ready <= 1'b1;
      wait_fire(1'b0);

      // Partial commit, more speculation, then recovery
      do_commits(5);
      rand_group(2'b11);
      wait_fire(1'b0);
      do_rollback();
      rand_group(2'b00);
      wait_fire(1'b0);
      rand_group(2'b01);
      wait_fire(1'b0);

      // Run the free list dry, then refill it by commits
      for (i = 0; i < 40 && free_count() >= 2; i++)
      begin
         rand_group(2'b11);
         wait_fire(1'b0);
      end
      rand_group(2'b11);
      repeat (4) @(posedge clk);
      do_commits(2);
      wait_fire(1'b0);
      do_commits(12);

      for (i = 0; i < 80; i++)
      begin
         if (rand_bits(4) == 0)
            do_rollback();
         else if (free_count() < 2 || rand_bits(2) == 0)
            do_commits(2 + int'(rand_bits(2)));
         rand_group(IW'(rand_bits(IW)));
         wait_fire(1'b1);
      end
      out_ready <= 1'b1;
      repeat (3) @(posedge clk);
      finish_run();
   end

endmodule

// File: rn_rename.f
source/rn_cfg_pkg.sv
source/rn_types_pkg.sv
source/rn_lane_if.sv
source/rn_free_list.sv
source/rn_rat.sv
source/rn_lane.sv
source/rn_dispatch_reg.sv
source/rn_rename_top.sv
dv/rn_rename_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the rename stage testbench with Verilator and run it
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module rn_rename_tb \
   -f rn_rename.f -o rn_rename_sim
./obj_dir/rn_rename_sim | tee sim.log

if grep -q "Test FAILED" sim.log; then
   echo "Simulation failed"
   exit 1
fi
echo "Simulation passed"
